/* logic/sd_cmd_pkg.sv */
`default_nettype none

package sd_cmd_pkg;

    // ======================================================================
    // Frame geometry
    // ======================================================================
    localparam int FRAME_BITS   = 48;
    // Start, direction, index and argument are covered by the CRC
    localparam int PAYLOAD_BITS = 40;
    localparam int CRC_BITS     = 7;
    localparam int INDEX_BITS   = 6;
    localparam int ARG_BITS     = 32;

    // Fixed bit values on the CMD line
    localparam logic START_BIT = 1'b0;
    localparam logic DIR_HOST  = 1'b1;
    localparam logic END_BIT   = 1'b1;

    // x^7 + x^3 + 1, top term implied
    localparam logic [CRC_BITS-1:0] CRC7_POLY = 7'h09;

    // ======================================================================
    // Frame layout, first bit on the line at the top
    // ======================================================================
    typedef struct packed {
        logic                  start_bit;
        logic                  dir_bit;
        logic [INDEX_BITS-1:0] index;
        logic [ARG_BITS-1:0]   arg;
        logic [CRC_BITS-1:0]   crc;
        logic                  end_bit;
    } sd_frame_fields_t;

    // Shift register view and field view of the same word
    typedef union packed {
        logic [FRAME_BITS-1:0] raw;
        sd_frame_fields_t      fields;
    } sd_frame_u;

endpackage

`default_nettype wire

/* logic/sd_clk_divider.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_clk_divider #(
    parameter int CLK_DIV = 4
) (
    input  wire  clk_fast,
    input  wire  init_resetPulse,
    output logic sd_clk,
    output logic fall_tick,
    output logic rise_tick
);

    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [CNT_W-1:0] div_cnt;
    logic             half_done;

    // Last cycle of a half period
    assign half_done = (div_cnt == CNT_W'(CLK_DIV - 1));

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            div_cnt   <= '0;
            sd_clk    <= 1'b0;
            fall_tick <= 1'b0;
            rise_tick <= 1'b0;
        end else begin
            fall_tick <= 1'b0;
            rise_tick <= 1'b0;
            if (half_done) begin
                div_cnt <= '0;
                sd_clk  <= ~sd_clk;
                // Ticks line up with the new sd_clk level
                fall_tick <= sd_clk;
                rise_tick <= ~sd_clk;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/sd_crc7.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_crc7
    import sd_cmd_pkg::*;
(
    input  wire                 clk_fast,
    input  wire                 init_resetPulse,
    input  wire                 crc_clear,
    input  wire                 crc_shift,
    input  wire                 crc_bit,
    output logic [CRC_BITS-1:0] crc
);

    logic feedback;

    // Feeding crc[6] back in makes feedback zero, so the register just shifts out
    assign feedback = crc_bit ^ crc[CRC_BITS-1];

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            crc <= '0;
        end else if (crc_clear) begin
            crc <= '0;
        end else if (crc_shift) begin
            crc <= {crc[CRC_BITS-2:0], 1'b0} ^ (feedback ? CRC7_POLY : '0);
        end
    end

endmodule

`default_nettype wire

/* logic/sd_cmd_sender.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_cmd_sender
    import sd_cmd_pkg::*;
(
    input  wire                  clk_fast,
    input  wire                  init_resetPulse,
    input  wire                  fall_tick,
    input  wire                  cmd_start,
    input  wire [INDEX_BITS-1:0] cmd_index,
    input  wire [ARG_BITS-1:0]   cmd_arg,
    output logic                 cmd_out,
    output logic                 cmd_oe,
    output logic                 cmd_done,
    output logic                 send_busy
);

    localparam int CNT_W = $clog2(FRAME_BITS + 1);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_SEND = 2'd1;
    localparam logic [1:0] S_DONE = 2'd2;

    logic [1:0]          state;
    logic [CNT_W-1:0]    bit_cnt;
    sd_frame_u           frame;
    logic                accept;
    logic                drive;
    logic                in_crc;
    logic                tx_bit;
    logic [CRC_BITS-1:0] crc;

    // ======================================================================
    // Bit selection
    // ======================================================================
    assign accept = (state == S_IDLE) && cmd_start;
    // bit_cnt holds the number of bits already on the line
    assign drive  = (state == S_SEND) && fall_tick && (bit_cnt != CNT_W'(FRAME_BITS));
    assign in_crc = (bit_cnt >= CNT_W'(PAYLOAD_BITS)) &&
                    (bit_cnt < CNT_W'(PAYLOAD_BITS + CRC_BITS));
    assign tx_bit = in_crc ? crc[CRC_BITS-1] : frame.raw[FRAME_BITS-1];

    assign send_busy = (state != S_IDLE);
    assign cmd_done  = (state == S_DONE);

    sd_crc7 u_crc7 (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .crc_clear       (accept),
        .crc_shift       (drive && (bit_cnt < CNT_W'(PAYLOAD_BITS + CRC_BITS))),
        .crc_bit         (tx_bit),
        .crc             (crc)
    );

    // ======================================================================
    // Control
    // ======================================================================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state   <= S_IDLE;
            bit_cnt <= '0;
            cmd_oe  <= 1'b0;
            cmd_out <= 1'b1;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cmd_start) begin
                        bit_cnt <= '0;
                        state   <= S_SEND;
                    end
                end
                S_SEND: begin
                    if (drive) begin
                        cmd_oe  <= 1'b1;
                        cmd_out <= tx_bit;
                        bit_cnt <= bit_cnt + 1'b1;
                    end else if (fall_tick) begin
                        // End bit has had its full period, release the line
                        cmd_oe  <= 1'b0;
                        cmd_out <= 1'b1;
                        state   <= S_DONE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Frame shift register, the CRC field is left zero and taken from u_crc7
    always_ff @(posedge clk_fast) begin
        if (accept) begin
            frame.fields.start_bit <= START_BIT;
            frame.fields.dir_bit   <= DIR_HOST;
            frame.fields.index     <= cmd_index;
            frame.fields.arg       <= cmd_arg;
            frame.fields.crc       <= '0;
            frame.fields.end_bit   <= END_BIT;
        end else if (drive) begin
            frame.raw <= {frame.raw[FRAME_BITS-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* logic/sd_resp_receiver.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_resp_receiver
    import sd_cmd_pkg::*;
#(
    parameter int NCR_MAX_BITS = 64
) (
    input  wire                   clk_fast,
    input  wire                   init_resetPulse,
    input  wire                   rise_tick,
    input  wire                   cmd_done,
    input  wire                   resp_expected,
    input  wire                   cmd_in,
    output logic                  resp_done,
    output logic                  resp_timeout,
    output logic                  resp_crc_err,
    output logic [INDEX_BITS-1:0] resp_index,
    output logic [ARG_BITS-1:0]   resp_status,
    output logic                  recv_busy
);

    localparam int CNT_W  = $clog2(FRAME_BITS + 1);
    localparam int WAIT_W = (NCR_MAX_BITS > 1) ? $clog2(NCR_MAX_BITS) : 1;

    localparam logic [2:0] R_IDLE = 3'd0;
    localparam logic [2:0] R_WAIT = 3'd1;
    localparam logic [2:0] R_RECV = 3'd2;
    localparam logic [2:0] R_DONE = 3'd3;
    localparam logic [2:0] R_TOUT = 3'd4;

    logic [2:0]          state;
    logic [CNT_W-1:0]    bit_cnt;
    logic [WAIT_W-1:0]   wait_cnt;
    sd_frame_u           frame;
    logic                arm;
    logic                start_seen;
    logic                sample;
    logic [CRC_BITS-1:0] crc;

    // ======================================================================
    // Sampling
    // ======================================================================
    assign arm        = (state == R_IDLE) && cmd_done && resp_expected;
    assign start_seen = (state == R_WAIT) && rise_tick && (cmd_in == START_BIT);
    assign sample     = start_seen || ((state == R_RECV) && rise_tick);

    sd_crc7 u_crc7 (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .crc_clear       (arm),
        .crc_shift       (sample && (bit_cnt < CNT_W'(PAYLOAD_BITS))),
        .crc_bit         (cmd_in),
        .crc             (crc)
    );

    // Result fields are read straight out of the frame
    assign resp_index   = frame.fields.index;
    assign resp_status  = frame.fields.arg;
    assign resp_done    = (state == R_DONE);
    assign resp_timeout = (state == R_TOUT);
    assign recv_busy    = (state != R_IDLE);
    assign resp_crc_err = resp_done &&
                          ((frame.fields.crc != crc) || (frame.fields.end_bit != END_BIT));

    // ======================================================================
    // Control
    // ======================================================================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state    <= R_IDLE;
            bit_cnt  <= '0;
            wait_cnt <= '0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (arm) begin
                        bit_cnt  <= '0;
                        wait_cnt <= '0;
                        state    <= R_WAIT;
                    end
                end
                R_WAIT: begin
                    if (start_seen) begin
                        bit_cnt <= CNT_W'(1);
                        state   <= R_RECV;
                    end else if (rise_tick) begin
                        // Ncr window used up
                        if (wait_cnt == WAIT_W'(NCR_MAX_BITS - 1)) begin
                            state <= R_TOUT;
                        end else begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end
                    end
                end
                R_RECV: begin
                    if (rise_tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == CNT_W'(FRAME_BITS - 1)) begin
                            state <= R_DONE;
                        end
                    end
                end
                default: begin
                    // R_DONE and R_TOUT last one cycle
                    state <= R_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_fast) begin
        if (sample) begin
            frame.raw <= {frame.raw[FRAME_BITS-2:0], cmd_in};
        end
    end

endmodule

`default_nettype wire

/* logic/sd_cmd_top.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_cmd_top
    import sd_cmd_pkg::*;
#(
    parameter int CLK_DIV      = 4,
    parameter int NCR_MAX_BITS = 64
) (
    input  wire                  clk_fast,
    input  wire                  init_resetPulse,
    input  wire                  cmd_start,
    input  wire [INDEX_BITS-1:0] cmd_index,
    input  wire [ARG_BITS-1:0]   cmd_arg,
    input  wire                  resp_expected,
    input  wire                  cmd_in,
    output wire                  sd_clk,
    output wire                  cmd_out,
    output wire                  cmd_oe,
    output wire                  cmd_done,
    output wire                  cmd_busy,
    output wire                  resp_done,
    output wire                  resp_timeout,
    output wire                  resp_crc_err,
    output wire [INDEX_BITS-1:0] resp_index,
    output wire [ARG_BITS-1:0]   resp_status
);

    wire fall_tick;
    wire rise_tick;
    wire send_busy;
    wire recv_busy;

    // Receiver takes over busy in the cycle after cmd_done
    assign cmd_busy = send_busy | recv_busy;

    sd_clk_divider #(
        .CLK_DIV (CLK_DIV)
    ) u_clk_divider (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .sd_clk          (sd_clk),
        .fall_tick       (fall_tick),
        .rise_tick       (rise_tick)
    );

    sd_cmd_sender u_sender (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .fall_tick       (fall_tick),
        .cmd_start       (cmd_start),
        .cmd_index       (cmd_index),
        .cmd_arg         (cmd_arg),
        .cmd_out         (cmd_out),
        .cmd_oe          (cmd_oe),
        .cmd_done        (cmd_done),
        .send_busy       (send_busy)
    );

    sd_resp_receiver #(
        .NCR_MAX_BITS (NCR_MAX_BITS)
    ) u_receiver (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .rise_tick       (rise_tick),
        .cmd_done        (cmd_done),
        .resp_expected   (resp_expected),
        .cmd_in          (cmd_in),
        .resp_done       (resp_done),
        .resp_timeout    (resp_timeout),
        .resp_crc_err    (resp_crc_err),
        .resp_index      (resp_index),
        .resp_status     (resp_status),
        .recv_busy       (recv_busy)
    );

endmodule

`default_nettype wire

/* verif/sd_cmd_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_cmd_assertions (
    input wire clk_fast,
    input wire init_resetPulse,
    input wire sd_clk,
    input wire fall_tick,
    input wire rise_tick,
    input wire cmd_out,
    input wire cmd_oe,
    input wire cmd_done,
    input wire cmd_busy,
    input wire resp_done,
    input wire resp_timeout,
    input wire resp_crc_err
);

    // ======================================================================
    // Protocol rules
    // ======================================================================
    oe_within_busy: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        cmd_oe |-> cmd_busy)
        else $error("cmd_oe is high while cmd_busy is low");

    cmd_done_single: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        cmd_done |=> !cmd_done)
        else $error("cmd_done stayed high for two cycles");

    resp_done_single: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        resp_done |=> !resp_done)
        else $error("resp_done stayed high for two cycles");

    resp_timeout_single: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        resp_timeout |=> !resp_timeout)
        else $error("resp_timeout stayed high for two cycles");

    done_or_timeout: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        !(resp_done && resp_timeout))
        else $error("resp_done and resp_timeout are high together");

    // Line idles high, everything else low
    reset_values: assert property (@(posedge clk_fast)
        init_resetPulse |=> (!sd_clk && !fall_tick && !rise_tick && !cmd_oe && cmd_out &&
                             !cmd_done && !cmd_busy && !resp_done && !resp_timeout &&
                             !resp_crc_err))
        else $error("control outputs are not at their reset values after reset");

endmodule

bind sd_cmd_top sd_cmd_assertions u_assertions (
    .clk_fast        (clk_fast),
    .init_resetPulse (init_resetPulse),
    .sd_clk          (sd_clk),
    .fall_tick       (fall_tick),
    .rise_tick       (rise_tick),
    .cmd_out         (cmd_out),
    .cmd_oe          (cmd_oe),
    .cmd_done        (cmd_done),
    .cmd_busy        (cmd_busy),
    .resp_done       (resp_done),
    .resp_timeout    (resp_timeout),
    .resp_crc_err    (resp_crc_err)
);

`default_nettype wire

/* verif/sd_cmd_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_cmd_tb
    import sd_cmd_pkg::*;
();

    localparam int CLK_DIV        = 4;
    localparam int NCR_MAX_BITS   = 64;
    localparam int TIMEOUT_CYCLES = 12000;

    localparam int REPLY_NONE    = 0;
    localparam int REPLY_GOOD    = 1;
    localparam int REPLY_BAD_CRC = 2;

    logic                  clk_fast = 1'b0;
    logic                  init_resetPulse;
    logic                  cmd_start;
    logic [INDEX_BITS-1:0] cmd_index;
    logic [ARG_BITS-1:0]   cmd_arg;
    logic                  resp_expected;
    logic                  cmd_in;
    logic                  sd_clk;
    logic                  cmd_out;
    logic                  cmd_oe;
    logic                  cmd_done;
    logic                  cmd_busy;
    logic                  resp_done;
    logic                  resp_timeout;
    logic                  resp_crc_err;
    logic [INDEX_BITS-1:0] resp_index;
    logic [ARG_BITS-1:0]   resp_status;

    int          seed = 51763;
    int          cycles = 0;
    int          card_reply = REPLY_NONE;
    int          frames_seen = 0;
    int          done_pulses = 0;
    int          timeout_pulses = 0;
    logic [47:0] cap_frame;
    logic [31:0] arg_rand;

    sd_cmd_top #(
        .CLK_DIV      (CLK_DIV),
        .NCR_MAX_BITS (NCR_MAX_BITS)
    ) DUT (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_start       (cmd_start),
        .cmd_index       (cmd_index),
        .cmd_arg         (cmd_arg),
        .resp_expected   (resp_expected),
        .cmd_in          (cmd_in),
        .sd_clk          (sd_clk),
        .cmd_out         (cmd_out),
        .cmd_oe          (cmd_oe),
        .cmd_done        (cmd_done),
        .cmd_busy        (cmd_busy),
        .resp_done       (resp_done),
        .resp_timeout    (resp_timeout),
        .resp_crc_err    (resp_crc_err),
        .resp_index      (resp_index),
        .resp_status     (resp_status)
    );

    always #2 clk_fast = ~clk_fast;

    always @(posedge clk_fast) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    always @(negedge clk_fast) begin
        if (resp_done) done_pulses <= done_pulses + 1;
        if (resp_timeout) timeout_pulses <= timeout_pulses + 1;
    end

    // SD CRC7, x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        c = 7'h00;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c  = {c[5:0], 1'b0};
            if (fb) c = c ^ 7'h09;
        end
        return c;
    endfunction

    task automatic check_value(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // ======================================================================
    // Card model
    // ======================================================================
    initial begin : card_model
        logic [47:0] shift;
        logic [47:0] reply;
        int          gap;
        cmd_in = 1'b1;
        forever begin
            do @(posedge sd_clk); while (cmd_oe !== 1'b1);
            shift = {47'b0, cmd_out};
            repeat (47) begin
                @(posedge sd_clk);
                shift = {shift[46:0], cmd_out};
            end
            cap_frame   = shift;
            frames_seen = frames_seen + 1;
            if (card_reply != REPLY_NONE) begin
                reply      = {1'b0, 1'b0, shift[45:40], ~shift[39:8], 7'h00, 1'b1};
                reply[7:1] = crc7_of(reply[47:8]);
                if (card_reply == REPLY_BAD_CRC) reply[3] = ~reply[3];
                gap = 2 + ($unsigned($random(seed)) % 9);
                // First negedge ends the end bit of the command
                repeat (gap + 1) @(negedge sd_clk);
                for (int i = 47; i >= 0; i--) begin
                    #1;
                    cmd_in = reply[i];
                    @(negedge sd_clk);
                end
                #1;
                cmd_in = 1'b1;
            end
        end
    end

    // ======================================================================
    // Command sequence with checks
    // ======================================================================
    task automatic run_command(input string name, input logic [5:0] index,
                               input logic [31:0] arg, input logic expect_resp,
                               input int reply);
        int          frames_before;
        int          done_before;
        int          tout_before;
        logic [47:0] frame;
        frames_before = frames_seen;
        done_before   = done_pulses;
        tout_before   = timeout_pulses;
        card_reply    = reply;
        @(posedge clk_fast);
        #1;
        cmd_index     = index;
        cmd_arg       = arg;
        resp_expected = expect_resp;
        cmd_start     = 1'b1;
        @(posedge clk_fast);
        #1;
        cmd_start = 1'b0;
        if (!expect_resp) begin
            // Start pulse while busy must not produce another frame
            repeat (20) @(posedge clk_fast);
            #1;
            cmd_start = 1'b1;
            @(posedge clk_fast);
            #1;
            cmd_start = 1'b0;
        end
        do @(negedge clk_fast); while (!cmd_done);
        frame = cap_frame;
        check_value(name, "frames", 32'(frames_before + 1), 32'(frames_seen));
        check_value(name, "start bit", 32'(1'b0), 32'(frame[47]));
        check_value(name, "direction bit", 32'(1'b1), 32'(frame[46]));
        check_value(name, "index", 32'(index), 32'(frame[45:40]));
        check_value(name, "argument", arg, frame[39:8]);
        check_value(name, "crc", 32'(crc7_of(frame[47:8])), 32'(frame[7:1]));
        check_value(name, "end bit", 32'(1'b1), 32'(frame[0]));
        if (expect_resp) begin
            do @(negedge clk_fast); while (!resp_done && !resp_timeout);
            if (reply == REPLY_NONE) begin
                check_value(name, "resp_timeout", 32'(1'b1), 32'(resp_timeout));
                check_value(name, "resp_done", 32'(1'b0), 32'(resp_done));
            end else begin
                check_value(name, "resp_done", 32'(1'b1), 32'(resp_done));
                check_value(name, "resp_index", 32'(index), 32'(resp_index));
                check_value(name, "resp_status", ~arg, resp_status);
                check_value(name, "resp_crc_err", 32'(reply == REPLY_BAD_CRC),
                            32'(resp_crc_err));
            end
            @(negedge clk_fast);
            check_value(name, "cmd_busy", 32'(1'b0), 32'(cmd_busy));
        end else begin
            @(negedge clk_fast);
            check_value(name, "cmd_busy", 32'(1'b0), 32'(cmd_busy));
            // Longer than the Ncr window
            repeat (600) @(negedge clk_fast);
            check_value(name, "frames", 32'(frames_before + 1), 32'(frames_seen));
            check_value(name, "resp_done pulses", 32'(done_before), 32'(done_pulses));
            check_value(name, "resp_timeout pulses", 32'(tout_before), 32'(timeout_pulses));
            check_value(name, "cmd_busy", 32'(1'b0), 32'(cmd_busy));
        end
    endtask

    initial begin : stimulus
        init_resetPulse = 1'b1;
        cmd_start       = 1'b0;
        cmd_index       = '0;
        cmd_arg         = '0;
        resp_expected   = 1'b0;
        repeat (16) @(posedge clk_fast);
        #1;
        init_resetPulse = 1'b0;

        run_command("good_response", 6'd17, 32'h1234_5678, 1'b1, REPLY_GOOD);
        arg_rand = $random(seed);
        run_command("random_argument", 6'd55, arg_rand, 1'b1, REPLY_GOOD);
        run_command("bad_crc", 6'd8, 32'h0000_01aa, 1'b1, REPLY_BAD_CRC);
        run_command("no_response", 6'd2, 32'hcafe_0001, 1'b1, REPLY_NONE);
        arg_rand = $random(seed);
        run_command("no_response_expected", 6'd0, arg_rand, 1'b0, REPLY_NONE);
        run_command("all_ones", 6'h3f, 32'hffff_ffff, 1'b1, REPLY_GOOD);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
logic/sd_cmd_pkg.sv
logic/sd_clk_divider.sv
logic/sd_crc7.sv
logic/sd_cmd_sender.sv
logic/sd_resp_receiver.sv
logic/sd_cmd_top.sv
verif/sd_cmd_assertions.sv
verif/sd_cmd_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module sd_cmd_tb -f vlog.f

./obj_dir/Vsd_cmd_tb 2>&1 | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
